//--- design/codec_config.svh
`ifndef CODEC_CONFIG_SVH
`define CODEC_CONFIG_SVH

// Command bus addresses
`define CODEC_CMD_TXGAIN_ADDR 6'h09
`define CODEC_CMD_RXGAIN_ADDR 6'h0a
`define CODEC_CMD_WRITE_ADDR  6'h3b

// Top byte a generic write must carry
`define CODEC_WRITE_SELECT 8'h06

// Codec registers behind the gain commands
`define CODEC_TXGAIN_REG 5'h0a
`define CODEC_RXGAIN_REG 5'h09

// Shadow values matching codec power-up state
`define CODEC_TXGAIN_RESET 4'hf
`define CODEC_RXGAIN_RESET 7'h40

// Init table covers registers 0x00 to 0x13
`define CODEC_INIT_LEN 20
`define CODEC_INIT_AW  5  // Counter must reach CODEC_INIT_LEN

// Serial write frame
`define CODEC_FRAME_W 16

// 1 means RX gain goes over the TX bus pins, so RX gain commands write nothing
`define CODEC_FAST_LNA 0

`endif

//--- design/codec_pkg.sv
package codec_pkg;

  // One serial write, shifted out MSB first
  typedef struct packed {
    logic [2:0] zero;      // Write flag and byte count, always 0
    logic [4:0] reg_addr;  // Target codec register
    logic [7:0] data;      // Register value
  } codec_frame_t;

  // Pending write from decoder to scheduler
  typedef struct packed {
    logic         valid;   // Frame waiting to go out
    codec_frame_t frame;
  } codec_write_t;

  // Gain commands, both gains share one word
  typedef struct packed {
    logic [3:0]  tx_gain;   // 31..28
    logic [20:0] rsvd;      // Unused
    logic [6:0]  rx_gain;   // 6..0
  } codec_gain_view_t;

  // Generic register write
  typedef struct packed {
    logic [7:0] sel;       // Must match the write selector
    logic [2:0] rsvd_a;
    logic [4:0] reg_addr;  // 20..16
    logic [7:0] rsvd_b;
    logic [7:0] data;      // 7..0
  } codec_write_view_t;

  // Command data word
  // Which view applies depends on cmd_addr
  typedef union packed {
    codec_gain_view_t  gain;
    codec_write_view_t wr;
    logic [31:0]       raw;
  } codec_cmd_word_u;

endpackage

//--- design/codec_cmd_decoder.sv
`timescale 1ns/1ps
`include "codec_config.svh"

module codec_cmd_decoder
  import codec_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [5:0]      cmd_addr,
  input  codec_cmd_word_u cmd_data,
  input  logic            cmd_rqst,
  output logic            cmd_ack,
  output codec_write_t    cmd_write,
  input  logic            cmd_write_taken
);

  logic [3:0]   tx_shadow;   // Last TX gain sent
  logic [6:0]   rx_shadow;   // Last RX gain sent
  logic         pend_valid;
  codec_frame_t pend_frame;
  codec_frame_t new_frame;   // Frame the current command would produce
  logic         need_write;
  logic         is_tx;
  logic         is_rx;
  logic [5:0]   rx_code;
  logic         seen;        // New request this cycle
  logic         slot_free;   // Pending slot free at this edge

  // RX gain to 6-bit PGA code
  assign rx_code = cmd_data.gain.rx_gain[6] ? cmd_data.gain.rx_gain[5:0] :
                   cmd_data.gain.rx_gain[5] ? ~cmd_data.gain.rx_gain[5:0] :
                   {1'b1, cmd_data.gain.rx_gain[4:0]};

  assign seen      = cmd_rqst && !cmd_ack;  // Request still held during the ack cycle
  assign slot_free = !pend_valid || cmd_write_taken;

  always_comb begin
    need_write = 1'b0;
    is_tx      = 1'b0;
    is_rx      = 1'b0;
    new_frame  = '0;
    case (cmd_addr)
      `CODEC_CMD_TXGAIN_ADDR: begin
        is_tx              = 1'b1;
        need_write         = (cmd_data.gain.tx_gain != tx_shadow);
        new_frame.reg_addr = `CODEC_TXGAIN_REG;
        new_frame.data     = {4'b0100, cmd_data.gain.tx_gain};
      end
      `CODEC_CMD_RXGAIN_ADDR: begin
        is_rx              = 1'b1;
        need_write         = (`CODEC_FAST_LNA == 0) && (cmd_data.gain.rx_gain != rx_shadow);
        new_frame.reg_addr = `CODEC_RXGAIN_REG;
        new_frame.data     = {2'b01, rx_code};
      end
      `CODEC_CMD_WRITE_ADDR: begin
        need_write         = (cmd_data.wr.sel == `CODEC_WRITE_SELECT);
        new_frame.reg_addr = cmd_data.wr.reg_addr;
        new_frame.data     = cmd_data.wr.data;
      end
      default: ;  // Unknown address, ack only
    endcase
  end

  // Ack, pending flag and shadows
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ack    <= 1'b0;
      pend_valid <= 1'b0;
      tx_shadow  <= `CODEC_TXGAIN_RESET;
      rx_shadow  <= `CODEC_RXGAIN_RESET;
    end else begin
      cmd_ack <= 1'b0;  // Single-cycle pulse
      if (cmd_write_taken)
        pend_valid <= 1'b0;
      if (seen) begin
        if (!need_write) begin
          cmd_ack <= 1'b1;
        end else if (slot_free) begin
          cmd_ack    <= 1'b1;
          pend_valid <= 1'b1;
          if (is_tx)
            tx_shadow <= cmd_data.gain.tx_gain;
          if (is_rx)
            rx_shadow <= cmd_data.gain.rx_gain;
        end
        // Otherwise hold off until the scheduler takes the old frame
      end
    end
  end

  // Frame payload, qualified by pend_valid
  always_ff @(posedge clk) begin
    if (seen && need_write && slot_free)
      pend_frame <= new_frame;
  end

  assign cmd_write = '{valid: pend_valid, frame: pend_frame};

endmodule

//--- design/codec_write_scheduler.sv
`timescale 1ns/1ps
`include "codec_config.svh"

module codec_write_scheduler
  import codec_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  codec_write_t cmd_write,
  output logic         cmd_write_taken,
  input  logic         shift_ready,
  output codec_frame_t frame,
  output logic         frame_start
);

  logic [`CODEC_INIT_AW-1:0] init_addr;  // Walks the table, parks at the end
  logic                      init_done;
  logic [8:0]                entry;      // {enable, data}
  logic                      init_fire;
  logic                      cmd_fire;
  codec_frame_t              init_frame;

  // Power-up table, bit 8 enables the write
  function automatic logic [8:0] init_entry(input logic [`CODEC_INIT_AW-1:0] addr);
    case (addr)
      5'h06:   return {1'b1, 8'h54};  // Second clock output off
      5'h07:   return {1'b1, 8'h30};  // Start DC offset cal, RX filter on
      5'h0b:   return {1'b1, 8'h00};  // RX PGA from register
      5'h0c:   return {1'b1, 8'h43};  // TX twos complement, interpolation
      5'h0d:   return {1'b1, 8'h03};  // RX twos complement
      5'h0e:   return {1'b1, 8'h81};  // IAMP setting
      5'h10:   return {1'b1, 8'h80};  // TX gain select
      5'h11:   return {1'b1, 8'h00};  // TX gain select, low part
      5'h12:   return {1'b1, 8'h00};
      default: return 9'h000;         // Left at codec default
    endcase
  endfunction

  assign init_done = (init_addr == `CODEC_INIT_AW'(`CODEC_INIT_LEN));
  assign entry     = init_entry(init_addr);

  // Init has priority, commands only once the table is done
  assign init_fire = !init_done && entry[8] && shift_ready;
  assign cmd_fire  = init_done && cmd_write.valid && shift_ready;

  assign frame_start     = init_fire || cmd_fire;
  assign cmd_write_taken = cmd_fire;  // Decoder drops valid on the same edge

  always_comb begin
    init_frame          = '0;
    init_frame.reg_addr = init_addr;  // Entry index is the register address
    init_frame.data     = entry[7:0];
  end

  assign frame = init_done ? cmd_write.frame : init_frame;

  // Skip disabled entries at once
  // Enabled ones wait for the shifter
  always_ff @(posedge clk) begin
    if (rst)
      init_addr <= '0;
    else if (!init_done && (!entry[8] || shift_ready))
      init_addr <= init_addr + 1'b1;
  end

endmodule

//--- design/codec_spi_shifter.sv
`timescale 1ns/1ps
`include "codec_config.svh"

module codec_spi_shifter
  import codec_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  codec_frame_t frame,
  input  logic         frame_start,
  output logic         shift_ready,
  output logic         sdio,
  output logic         sclk,
  output logic         sen_n
);

  typedef enum logic {
    SH_IDLE,
    SH_SHIFT
  } sh_state_t;

  sh_state_t                          state;
  logic [`CODEC_FRAME_W-1:0]          shreg;    // MSB drives sdio
  logic [$clog2(`CODEC_FRAME_W)-1:0]  bit_cnt;  // Bits left after this one

  assign sdio = shreg[`CODEC_FRAME_W-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= SH_IDLE;
      shreg       <= '0;  // Keeps sdio low out of reset
      bit_cnt     <= '0;
      sclk        <= 1'b0;
      sen_n       <= 1'b1;
      shift_ready <= 1'b0;
    end else begin
      case (state)
        SH_IDLE: begin
          sclk <= 1'b0;
          if (frame_start) begin
            shreg       <= frame;
            bit_cnt     <= '1;  // 15 more bits after the first
            sen_n       <= 1'b0;
            shift_ready <= 1'b0;
            state       <= SH_SHIFT;
          end else begin
            sen_n       <= 1'b1;   // Released one cycle after last fall
            shift_ready <= sen_n;  // Ready once enable has been high a cycle
          end
        end
        SH_SHIFT: begin
          if (!sclk) begin
            sclk <= 1'b1;  // Codec samples here
          end else begin
            // Falling edge, next bit out
            sclk    <= 1'b0;
            shreg   <= {shreg[`CODEC_FRAME_W-2:0], 1'b0};
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0)
              state <= SH_IDLE;
          end
        end
        default: state <= SH_IDLE;
      endcase
    end
  end

endmodule

//--- design/codec_ctrl_top.sv
`timescale 1ns/1ps

module codec_ctrl_top
  import codec_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [5:0]      cmd_addr,
  input  codec_cmd_word_u cmd_data,
  input  logic            cmd_rqst,
  output logic            cmd_ack,
  output logic            sdio,
  output logic            sclk,
  output logic            sen_n
);

  codec_write_t cmd_write;        // Decoder pending write
  logic         cmd_write_taken;
  codec_frame_t frame;            // Next frame to shift
  logic         frame_start;
  logic         shift_ready;

  // Command side
  codec_cmd_decoder codec_cmd_decoder_i (
    .clk             (clk),
    .rst             (rst),
    .cmd_addr        (cmd_addr),
    .cmd_data        (cmd_data),
    .cmd_rqst        (cmd_rqst),
    .cmd_ack         (cmd_ack),
    .cmd_write       (cmd_write),
    .cmd_write_taken (cmd_write_taken)
  );

  // Init table and arbitration
  codec_write_scheduler codec_write_scheduler_i (
    .clk             (clk),
    .rst             (rst),
    .cmd_write       (cmd_write),
    .cmd_write_taken (cmd_write_taken),
    .shift_ready     (shift_ready),
    .frame           (frame),
    .frame_start     (frame_start)
  );

  codec_spi_shifter codec_spi_shifter_i (
    .clk         (clk),
    .rst         (rst),
    .frame       (frame),
    .frame_start (frame_start),
    .shift_ready (shift_ready),
    .sdio        (sdio),
    .sclk        (sclk),
    .sen_n       (sen_n)
  );

endmodule

//--- bench/codec_spi_monitor.sv
`timescale 1ns/1ps

module codec_spi_monitor (
  input  logic        clk,
  input  logic        rst,
  input  logic        sdio,
  input  logic        sclk,
  input  logic        sen_n,
  output logic        word_valid,  // One cycle per finished frame
  output logic [15:0] word,        // Bits captured at sclk rises, MSB first
  output logic [5:0]  rise_cnt,    // sclk rises seen while sen_n low
  output logic        sdio_moved,  // sdio changed in a cycle sclk rose
  output logic        stray_sclk   // sclk rose with enable high
);

  logic        sclk_q;   // Pin values one cycle back
  logic        sdio_q;
  logic        sen_n_q;
  logic [15:0] shift;    // Frame being collected
  logic [5:0]  rises;
  logic        moved;

  // Pins change on the rising clock, so sample between edges
  always_ff @(negedge clk) begin
    if (rst) begin
      sclk_q     <= 1'b0;
      sdio_q     <= 1'b0;
      sen_n_q    <= 1'b1;
      shift      <= '0;
      rises      <= '0;
      moved      <= 1'b0;
      word_valid <= 1'b0;
      word       <= '0;
      rise_cnt   <= '0;
      sdio_moved <= 1'b0;
      stray_sclk <= 1'b0;
    end else begin
      sclk_q     <= sclk;
      sdio_q     <= sdio;
      sen_n_q    <= sen_n;
      word_valid <= 1'b0;
      stray_sclk <= sclk && !sclk_q && sen_n;
      if (!sen_n && sen_n_q) begin
        // Enable just fell, start of frame
        shift <= '0;
        rises <= '0;
        moved <= 1'b0;
      end else if (!sen_n && sclk && !sclk_q) begin
        shift <= {shift[14:0], sdio};  // Codec would sample here
        rises <= rises + 6'd1;
        if (sdio != sdio_q)
          moved <= 1'b1;  // Data must settle while sclk is low
      end
      if (sen_n && !sen_n_q) begin
        word_valid <= 1'b1;  // Enable released, frame complete
        word       <= shift;
        rise_cnt   <= rises;
        sdio_moved <= moved;
      end
    end
  end

endmodule

//--- bench/codec_tb.sv
`timescale 1ns/1ps
`include "codec_config.svh"

module codec_tb
  import codec_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;  // 9 init frames plus 300 commands at ~40 cycles
  localparam int RANDOM_CMDS    = 289;    // On top of 11 directed ones
  localparam int DRAIN_CYCLES   = 100;    // Two frames of ~35 cycles still in flight at most

  logic            clk;
  logic            rst;
  logic [5:0]      cmd_addr;
  codec_cmd_word_u cmd_data;
  logic            cmd_rqst;
  logic            cmd_ack;
  logic            sdio;
  logic            sclk;
  logic            sen_n;
  logic            mon_valid;
  logic [15:0]     mon_word;
  logic [5:0]      mon_rises;
  logic            mon_moved;
  logic            mon_stray;
  logic [15:0]     expected_q[$];  // Frames in the order they must leave
  logic [15:0]     want_word;
  logic [3:0]      tx_shadow;      // Reference copies of the gain shadows
  logic [6:0]      rx_shadow;
  logic [31:0]     r;
  logic [31:0]     d;
  integer          seed;
  int              cycles = 0;
  int              frames_seen = 0;
  int              drain;          // Cycles spent waiting for the last frames

  codec_ctrl_top codec_ctrl_top_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .cmd_rqst (cmd_rqst),
    .cmd_ack  (cmd_ack),
    .sdio     (sdio),
    .sclk     (sclk),
    .sen_n    (sen_n)
  );

  codec_spi_monitor codec_spi_monitor_i (
    .clk        (clk),
    .rst        (rst),
    .sdio       (sdio),
    .sclk       (sclk),
    .sen_n      (sen_n),
    .word_valid (mon_valid),
    .word       (mon_word),
    .rise_cnt   (mon_rises),
    .sdio_moved (mon_moved),
    .stray_sclk (mon_stray)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Bit 16 set when the command must produce a frame
  function automatic logic [16:0] expected_frame(input logic [5:0] addr,
      input logic [31:0] data, input logic [3:0] tx_sh, input logic [6:0] rx_sh);
    logic [6:0] g;
    logic [5:0] code;
    expected_frame = '0;
    g    = data[6:0];
    code = g[6] ? g[5:0] : (g[5] ? ~g[5:0] : {1'b1, g[4:0]});  // PGA code rule
    case (addr)
      `CODEC_CMD_TXGAIN_ADDR:
        if (data[31:28] != tx_sh)
          expected_frame = {1'b1, 3'b000, 5'h0a, 4'b0100, data[31:28]};
      `CODEC_CMD_RXGAIN_ADDR:
        if ((`CODEC_FAST_LNA == 0) && (g != rx_sh))
          expected_frame = {1'b1, 3'b000, 5'h09, 2'b01, code};
      `CODEC_CMD_WRITE_ADDR:
        if (data[31:24] == 8'h06)
          expected_frame = {1'b1, 3'b000, data[20:16], data[7:0]};
      default: ;  // Unknown address is only acked
    endcase
  endfunction

  // Called on a falling edge, returns on the falling edge that sees the ack
  task automatic issue_cmd(input logic [5:0] addr, input logic [31:0] data);
    logic [16:0] want;
    int          waited;
    want   = expected_frame(addr, data, tx_shadow, rx_shadow);
    waited = 0;
    if (want[16]) begin
      expected_q.push_back(want[15:0]);
      if (addr == `CODEC_CMD_TXGAIN_ADDR)
        tx_shadow = data[31:28];
      if (addr == `CODEC_CMD_RXGAIN_ADDR)
        rx_shadow = data[6:0];
    end
    cmd_addr     = addr;
    cmd_data.raw = data;
    cmd_rqst     = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!cmd_ack);
    // No write means no back-pressure; 2 covers the previous ack cycle
    if (!want[16])
      assert (waited <= 2) else
        abort_run($sformatf("command %02h with no write waited %0d cycles for cmd_ack",
                            addr, waited));
  endtask

  task automatic idle_gap(input int n);
    cmd_rqst = 1'b0;
    repeat (n) begin
      @(negedge clk);
      assert (!cmd_ack) else abort_run("cmd_ack pulsed with no request pending");
    end
  endtask

  // Monitor outputs settle on the falling edge so compare on the rising one
  always @(posedge clk) begin
    if (mon_valid) begin
      assert (mon_rises == 6'd16) else
        abort_run($sformatf("error at %0t ns: sclk rises got %0d expected 16",
                            $time, mon_rises));
      assert (!mon_moved) else abort_run("sdio changed in a cycle where sclk rose");
      assert (expected_q.size() > 0) else
        abort_run($sformatf("unexpected frame %04h on the serial pins", mon_word));
      want_word = expected_q.pop_front();
      assert (mon_word == want_word) else
        abort_run($sformatf("error at %0t ns: sdio frame got %04h expected %04h",
                            $time, mon_word, want_word));
      frames_seen++;
    end
    assert (!mon_stray) else abort_run("sclk pulsed while sen_n was high");
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
      abort_run($sformatf("run timed out after %0d cycles", cycles));
  end

  initial begin
    seed         = 21;
    rst          = 1'b1;
    cmd_rqst     = 1'b0;
    cmd_addr     = '0;
    cmd_data.raw = '0;
    tx_shadow    = 4'hf;   // Codec power-up gains
    rx_shadow    = 7'h40;
    // Power-up table in ascending register order
    expected_q.push_back({3'b000, 5'h06, 8'h54});
    expected_q.push_back({3'b000, 5'h07, 8'h30});
    expected_q.push_back({3'b000, 5'h0b, 8'h00});
    expected_q.push_back({3'b000, 5'h0c, 8'h43});
    expected_q.push_back({3'b000, 5'h0d, 8'h03});
    expected_q.push_back({3'b000, 5'h0e, 8'h81});
    expected_q.push_back({3'b000, 5'h10, 8'h80});
    expected_q.push_back({3'b000, 5'h11, 8'h00});
    expected_q.push_back({3'b000, 5'h12, 8'h00});
    repeat (10) @(negedge clk);
    assert (sen_n === 1'b1) else
      abort_run($sformatf("error at %0t ns: sen_n got %b expected 1", $time, sen_n));
    assert (sclk === 1'b0) else
      abort_run($sformatf("error at %0t ns: sclk got %b expected 0", $time, sclk));
    assert (sdio === 1'b0) else
      abort_run($sformatf("error at %0t ns: sdio got %b expected 0", $time, sdio));
    assert (cmd_ack === 1'b0) else
      abort_run($sformatf("error at %0t ns: cmd_ack got %b expected 0", $time, cmd_ack));
    rst = 1'b0;

    // Directed commands back to back while init frames run
    issue_cmd(`CODEC_CMD_WRITE_ADDR, 32'h0615_00a5);
    issue_cmd(`CODEC_CMD_WRITE_ADDR, 32'h0603_005a);
    issue_cmd(`CODEC_CMD_TXGAIN_ADDR, 32'h3000_0000);
    issue_cmd(`CODEC_CMD_TXGAIN_ADDR, 32'h3000_0000);  // Repeat gives no frame
    issue_cmd(`CODEC_CMD_RXGAIN_ADDR, 32'h0000_0045);  // Bit 6 rule
    issue_cmd(`CODEC_CMD_RXGAIN_ADDR, 32'h0000_0025);  // Inversion rule
    issue_cmd(`CODEC_CMD_RXGAIN_ADDR, 32'h0000_0005);  // Leading one rule
    issue_cmd(`CODEC_CMD_RXGAIN_ADDR, 32'h0000_0005);
    issue_cmd(`CODEC_CMD_WRITE_ADDR, 32'h0715_00ff);   // Wrong selector
    issue_cmd(6'h15, 32'hdead_beef);                   // Unknown address
    issue_cmd(`CODEC_CMD_TXGAIN_ADDR, 32'hf000_0000);

    for (int i = 0; i < RANDOM_CMDS; i++) begin
      r = $random(seed);
      d = $random(seed);
      case (r[2:0])
        3'd0, 3'd1: issue_cmd(`CODEC_CMD_TXGAIN_ADDR, r[8] ? {tx_shadow, d[27:0]} : d);
        3'd2, 3'd3: issue_cmd(`CODEC_CMD_RXGAIN_ADDR, r[8] ? {d[31:7], rx_shadow} : d);
        3'd4:       issue_cmd(`CODEC_CMD_WRITE_ADDR, r[9] ? {8'h06, d[23:0]} : d);
        3'd5, 3'd6: issue_cmd(`CODEC_CMD_WRITE_ADDR, {8'h06, d[23:0]});
        default:    issue_cmd(6'h10 | {1'b0, r[14:10]}, d);  // 0x10..0x1f is never decoded
      endcase
      if (r[31:30] == 2'b00)
        idle_gap(int'(r[29:28]) + 1);
    end

    cmd_rqst = 1'b0;
    drain    = 0;
    while (expected_q.size() != 0 && drain < DRAIN_CYCLES) begin
      @(negedge clk);
      drain++;
    end

    if (expected_q.size() == 0) begin
      repeat (100) @(negedge clk);  // Quiet window for stray frames
      $display("%0d frames checked", frames_seen);
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("%0d expected frames never reached the pins", expected_q.size());
      $display("RESULT: FAIL");
      $fatal(1, "missing frames");
    end
  end

endmodule

//--- verilog.f
+incdir+design
design/codec_pkg.sv
design/codec_cmd_decoder.sv
design/codec_write_scheduler.sv
design/codec_spi_shifter.sv
design/codec_ctrl_top.sv
bench/codec_spi_monitor.sv
bench/codec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the codec controller testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module codec_tb -o codec_sim

# The log decides the result, not the exit status
./obj_dir/codec_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "simulation failed"
  exit 1
fi

# A run that ended without a verdict also fails
grep -q "RESULT: PASS" "$LOG"
